/* hdl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  // Barrel-threaded core with four interleaved slices
  localparam int NUM_THREADS = 4;

  typedef logic [1:0] thread_id_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        wr;
    logic [3:0]  mask;
    logic [31:0] data;
    logic [2:0]  dst;
  } core_req_t;

  // One 64-bit beat seen as two words or as eight byte lanes
  typedef union packed {
    logic [1:0][31:0] words;
    logic [7:0][7:0]  bytes;
  } bus_data_u;

  typedef struct packed {
    thread_id_t  id;
    logic [31:0] addr;
    bus_data_u   data;
    logic [7:0]  strb;
  } bus_wr_t;

  typedef struct packed {
    thread_id_t  id;
    logic [31:0] addr;
  } bus_rd_t;

  typedef struct packed {
    thread_id_t id;
    bus_data_u  data;
  } rd_resp_t;

  typedef struct packed {
    thread_id_t  slice;
    logic [2:0]  dst;
    logic [31:0] data;
  } load_ret_t;

endpackage

`default_nettype wire

/* hdl/thread_bus_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module thread_bus_unit
  import bus_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RST,
  input  thread_id_t             slice,
  input  logic                   req_vld,
  input  core_req_t              req,
  output logic [NUM_THREADS-1:0] stall,
  output logic                   wr_vld,
  output bus_wr_t                wr,
  input  logic                   wr_rdy,
  input  logic                   wr_ack,
  input  thread_id_t             wr_ack_id,
  output logic                   rd_vld,
  output bus_rd_t                rd,
  input  logic                   rd_rdy,
  input  logic                   rsp_vld,
  input  rd_resp_t               rsp,
  output logic                   load_vld,
  output load_ret_t              load
);

  // One transaction slot per thread, written when the core issues
  core_req_t slot [NUM_THREADS];

  logic [NUM_THREADS-1:0] wr_req_vec;
  logic [NUM_THREADS-1:0] rd_req_vec;
  logic [NUM_THREADS-1:0] wr_ack_vec;
  logic [NUM_THREADS-1:0] rd_ack_vec;
  logic [NUM_THREADS-1:0] pend_wr;
  logic [NUM_THREADS-1:0] pend_rd;
  logic [NUM_THREADS-1:0] wr_sent;
  logic [NUM_THREADS-1:0] rd_sent;
  logic [NUM_THREADS-1:0] wr_launch_vec;
  logic [NUM_THREADS-1:0] rd_launch_vec;

  thread_id_t wr_ptr;
  thread_id_t rd_ptr;
  logic       wr_launch;
  logic       rd_launch;

  logic      rsp_vld_d1;
  rd_resp_t  rsp_d1;
  core_req_t rsp_slot;
  logic      word_sel;
  logic [31:0] rsp_word;
  logic [31:0] load_data;

  // Decode the request and acknowledge strobes into one-hot thread vectors
  always_comb
  begin
    wr_req_vec = '0;
    rd_req_vec = '0;
    wr_ack_vec = '0;
    rd_ack_vec = '0;
    if (req_vld)
    begin
      if (req.wr)
        wr_req_vec[slice] = 1'b1;
      else
        rd_req_vec[slice] = 1'b1;
    end
    if (wr_ack)
      wr_ack_vec[wr_ack_id] = 1'b1;
    if (rsp_vld)
      rd_ack_vec[rsp.id] = 1'b1;
  end

  always_ff @(posedge CLK)
  begin
    if (req_vld)
      slot[slice] <= req;
  end

  // Stall follows pending by one cycle on both edges
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      pend_wr <= '0;
      pend_rd <= '0;
      stall   <= '0;
    end
    else
    begin
      pend_wr <= (pend_wr & ~wr_ack_vec) | wr_req_vec;
      pend_rd <= (pend_rd & ~rd_ack_vec) | rd_req_vec;
      stall   <= pend_wr | pend_rd;
    end
  end

  // A scanner launches when idle and its current thread has an unsent transaction
  assign wr_launch = !wr_vld && pend_wr[wr_ptr] && !wr_sent[wr_ptr];
  assign rd_launch = !rd_vld && pend_rd[rd_ptr] && !rd_sent[rd_ptr];

  always_comb
  begin
    wr_launch_vec = '0;
    rd_launch_vec = '0;
    wr_launch_vec[wr_ptr] = wr_launch;
    rd_launch_vec[rd_ptr] = rd_launch;
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      wr_sent <= '0;
      rd_sent <= '0;
    end
    else
    begin
      wr_sent <= (wr_sent & ~wr_ack_vec) | wr_launch_vec;
      rd_sent <= (rd_sent & ~rd_ack_vec) | rd_launch_vec;
    end
  end

  // Write scanner holds its transfer until ready, then moves to the next thread
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      wr_vld <= 1'b0;
      wr_ptr <= '0;
    end
    else if (wr_vld)
    begin
      if (wr_rdy)
      begin
        wr_vld <= 1'b0;
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
    else if (wr_launch)
      wr_vld <= 1'b1;
    else
      wr_ptr <= wr_ptr + 1'b1;
  end

  // The store word is copied to both halves, strobes pick the half
  always_ff @(posedge CLK)
  begin
    if (wr_launch)
    begin
      wr.id         <= wr_ptr;
      wr.addr       <= slot[wr_ptr].addr;
      wr.data.words <= {2{slot[wr_ptr].data}};
      wr.strb       <= slot[wr_ptr].addr[2] ? {slot[wr_ptr].mask, 4'b0000}
                                            : {4'b0000, slot[wr_ptr].mask};
    end
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      rd_vld <= 1'b0;
      rd_ptr <= '0;
    end
    else if (rd_vld)
    begin
      if (rd_rdy)
      begin
        rd_vld <= 1'b0;
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
    else if (rd_launch)
      rd_vld <= 1'b1;
    else
      rd_ptr <= rd_ptr + 1'b1;
  end

  always_ff @(posedge CLK)
  begin
    if (rd_launch)
    begin
      rd.id   <= rd_ptr;
      rd.addr <= slot[rd_ptr].addr;
    end
  end

  // Response is registered once before formatting
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      rsp_vld_d1 <= 1'b0;
    else
      rsp_vld_d1 <= rsp_vld;
  end

  always_ff @(posedge CLK)
  begin
    if (rsp_vld)
      rsp_d1 <= rsp;
  end

  // The slot stays intact here since stall is still high for this thread
  always_comb
  begin
    rsp_slot = slot[rsp_d1.id];
    word_sel = rsp_slot.addr[2];
    rsp_word = rsp_d1.data.words[word_sel];
    case (rsp_slot.mask)
      4'b0001: load_data = {24'd0, rsp_d1.data.bytes[{word_sel, 2'd0}]};
      4'b0010: load_data = {24'd0, rsp_d1.data.bytes[{word_sel, 2'd1}]};
      4'b0100: load_data = {24'd0, rsp_d1.data.bytes[{word_sel, 2'd2}]};
      4'b1000: load_data = {24'd0, rsp_d1.data.bytes[{word_sel, 2'd3}]};
      4'b0011: load_data = {16'd0, rsp_word[15:0]};
      4'b1100: load_data = {16'd0, rsp_word[31:16]};
      default: load_data = rsp_word;
    endcase
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      load_vld <= 1'b0;
    else
      load_vld <= rsp_vld_d1;
  end

  always_ff @(posedge CLK)
  begin
    if (rsp_vld_d1)
    begin
      load.slice <= rsp_d1.id;
      load.dst   <= rsp_slot.dst;
      load.data  <= load_data;
    end
  end

endmodule

`default_nettype wire

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
(
  input  logic CLK,
  input  logic RST,
  input  logic wr_req,
  input  logic rd_req,
  output logic wr_gnt,
  output logic rd_gnt
);

  // Low favours the write path, high favours the read path
  logic prio_rd;

  always_comb
  begin
    wr_gnt = wr_req && (!rd_req || !prio_rd);
    rd_gnt = rd_req && (!wr_req || prio_rd);
  end

  // Only a contested grant moves priority to the other side
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      prio_rd <= 1'b0;
    else if (wr_req && rd_req)
      prio_rd <= !prio_rd;
  end

endmodule

`default_nettype wire

/* hdl/bus_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_memory
  import bus_pkg::*;
#(
  parameter int MEM_DEPTH = 256
)
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       wr_vld,
  input  bus_wr_t    wr,
  output logic       wr_rdy,
  output logic       wr_ack,
  output thread_id_t wr_ack_id,
  input  logic       rd_vld,
  input  bus_rd_t    rd,
  output logic       rd_rdy,
  output logic       rsp_vld,
  output rd_resp_t   rsp
);

  localparam int AW = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

  bus_data_u ram [MEM_DEPTH];

  logic          wr_go;
  logic          rd_go;
  logic [AW-1:0] wr_idx;
  logic [AW-1:0] rd_idx;

  // Single port, so the two paths take turns through the arbiter
  mem_arbiter i_arb
  (
    .CLK    (CLK),
    .RST    (RST),
    .wr_req (wr_vld),
    .rd_req (rd_vld),
    .wr_gnt (wr_rdy),
    .rd_gnt (rd_rdy)
  );

  assign wr_go  = wr_vld && wr_rdy;
  assign rd_go  = rd_vld && rd_rdy;
  assign wr_idx = AW'(wr.addr[31:3] % MEM_DEPTH);
  assign rd_idx = AW'(rd.addr[31:3] % MEM_DEPTH);

  // Byte lanes are merged under the write strobe
  always_ff @(posedge CLK)
  begin
    if (wr_go)
    begin
      for (int b = 0; b < 8; b++)
      begin
        if (wr.strb[b])
          ram[wr_idx].bytes[b] <= wr.data.bytes[b];
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (wr_go)
      wr_ack_id <= wr.id;
    if (rd_go)
    begin
      rsp.id   <= rd.id;
      rsp.data <= ram[rd_idx];
    end
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      wr_ack  <= 1'b0;
      rsp_vld <= 1'b0;
    end
    else
    begin
      wr_ack  <= wr_go;
      rsp_vld <= rd_go;
    end
  end

endmodule

`default_nettype wire

/* hdl/bus_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_subsystem
  import bus_pkg::*;
#(
  parameter int MEM_DEPTH = 256
)
(
  input  logic                   CLK,
  input  logic                   RST,
  input  thread_id_t             slice,
  input  logic                   req_vld,
  input  core_req_t              req,
  output logic [NUM_THREADS-1:0] stall,
  output logic                   load_vld,
  output load_ret_t              load
);

  logic       wr_vld;
  bus_wr_t    wr;
  logic       wr_rdy;
  logic       wr_ack;
  thread_id_t wr_ack_id;
  logic       rd_vld;
  bus_rd_t    rd;
  logic       rd_rdy;
  logic       rsp_vld;
  rd_resp_t   rsp;

  thread_bus_unit i_unit
  (
    .CLK       (CLK),
    .RST       (RST),
    .slice     (slice),
    .req_vld   (req_vld),
    .req       (req),
    .stall     (stall),
    .wr_vld    (wr_vld),
    .wr        (wr),
    .wr_rdy    (wr_rdy),
    .wr_ack    (wr_ack),
    .wr_ack_id (wr_ack_id),
    .rd_vld    (rd_vld),
    .rd        (rd),
    .rd_rdy    (rd_rdy),
    .rsp_vld   (rsp_vld),
    .rsp       (rsp),
    .load_vld  (load_vld),
    .load      (load)
  );

  bus_memory #(
    .MEM_DEPTH (MEM_DEPTH)
  ) i_mem
  (
    .CLK       (CLK),
    .RST       (RST),
    .wr_vld    (wr_vld),
    .wr        (wr),
    .wr_rdy    (wr_rdy),
    .wr_ack    (wr_ack),
    .wr_ack_id (wr_ack_id),
    .rd_vld    (rd_vld),
    .rd        (rd),
    .rd_rdy    (rd_rdy),
    .rsp_vld   (rsp_vld),
    .rsp       (rsp)
  );

endmodule

`default_nettype wire

/* sim/bus_unit_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_unit_checker
  import bus_pkg::*;
(
  input logic                   CLK,
  input logic                   RST,
  input thread_id_t             slice,
  input logic                   req_vld,
  input logic [NUM_THREADS-1:0] pend_wr,
  input logic [NUM_THREADS-1:0] pend_rd,
  input logic [NUM_THREADS-1:0] stall,
  input logic                   wr_vld,
  input bus_wr_t                wr,
  input logic                   wr_rdy,
  input logic                   rd_vld,
  input bus_rd_t                rd,
  input logic                   rd_rdy,
  input logic                   rsp_vld,
  input logic                   load_vld
);

  // A transfer waiting for ready keeps its valid and its payload
  assert property (@(posedge CLK) disable iff (RST)
                   wr_vld && !wr_rdy |=> wr_vld && $stable(wr))
    else $error("write transfer changed before it was accepted");

  assert property (@(posedge CLK) disable iff (RST)
                   rd_vld && !rd_rdy |=> rd_vld && $stable(rd))
    else $error("read transfer changed before it was accepted");

  assert property (@(posedge CLK) disable iff (RST)
                   req_vld |-> !pend_wr[slice] && !pend_rd[slice])
    else $error("request issued for a thread that is still pending");

  // The response goes through one register and the formatting stage
  assert property (@(posedge CLK) disable iff (RST) load_vld == $past(rsp_vld, 2))
    else $error("load_vld not exactly two cycles after rsp_vld");

  assert property (@(posedge CLK)
                   RST |-> stall == '0 && !wr_vld && !rd_vld && !rsp_vld && !load_vld)
    else $error("control output high during reset");

endmodule

bind thread_bus_unit bus_unit_checker i_chk
(
  .CLK      (CLK),
  .RST      (RST),
  .slice    (slice),
  .req_vld  (req_vld),
  .pend_wr  (pend_wr),
  .pend_rd  (pend_rd),
  .stall    (stall),
  .wr_vld   (wr_vld),
  .wr       (wr),
  .wr_rdy   (wr_rdy),
  .rd_vld   (rd_vld),
  .rd       (rd),
  .rd_rdy   (rd_rdy),
  .rsp_vld  (rsp_vld),
  .load_vld (load_vld)
);

`default_nettype wire

/* sim/tb_bus_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bus_subsystem
  import bus_pkg::*;
();

  localparam int INIT_OPS       = 16;
  localparam int OPS_PER_THREAD = INIT_OPS + 100;
  localparam int TOTAL_OPS      = NUM_THREADS * OPS_PER_THREAD;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_OPS;

  logic                   CLK;
  logic                   RST;
  thread_id_t             slice;
  logic                   req_vld;
  core_req_t              req;
  logic [NUM_THREADS-1:0] stall;
  logic                   load_vld;
  load_ret_t              load;

  // Reference memory, one 64-bit beat per entry
  logic [63:0] model_mem [256];
  load_ret_t   exp_q [NUM_THREADS][$];
  load_ret_t   exp_ret;

  logic [31:0]            rng_state;
  logic [NUM_THREADS-1:0] busy;
  logic [NUM_THREADS-1:0] is_load;
  int                     age [NUM_THREADS];
  int                     ops_done [NUM_THREADS];
  int                     loads_issued;
  int                     loads_seen;
  int                     cycles;

  bus_subsystem #(
    .MEM_DEPTH (256)
  ) i_dut
  (
    .CLK      (CLK),
    .RST      (RST),
    .slice    (slice),
    .req_vld  (req_vld),
    .req      (req),
    .stall    (stall),
    .load_vld (load_vld),
    .load     (load)
  );

  initial
  begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Seven named masks plus one that falls back to a whole word
  function automatic logic [3:0] pick_mask(input logic [2:0] sel);
    case (sel)
      3'd0:    return 4'b1111;
      3'd1:    return 4'b0001;
      3'd2:    return 4'b0010;
      3'd3:    return 4'b0100;
      3'd4:    return 4'b1000;
      3'd5:    return 4'b0011;
      3'd6:    return 4'b1100;
      default: return 4'b0101;
    endcase
  endfunction

  // Thread t owns beats t*32 to t*32+7
  function automatic logic [31:0] region_addr(input int t, input int w, input logic hi);
    return (32'(t) << 8) | (32'(w) << 3) | (32'(hi) << 2);
  endfunction

  function automatic logic [31:0] expected_load(input logic [63:0] beat,
                                                input logic [31:0] addr,
                                                input logic [3:0]  mask);
    logic [31:0] word;
    word = addr[2] ? beat[63:32] : beat[31:0];
    for (int i = 0; i < 4; i++)
    begin
      if (mask == 4'(1 << i))
        return {24'd0, word[i*8 +: 8]};
    end
    if (mask == 4'b0011)
      return {16'd0, word[15:0]};
    if (mask == 4'b1100)
      return {16'd0, word[31:16]};
    return word;
  endfunction

  function automatic logic work_left();
    logic left;
    left = |busy;
    for (int t = 0; t < NUM_THREADS; t++)
      left = left | (ops_done[t] < OPS_PER_THREAD);
    return left;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("ERROR t=%0t %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic apply_store(input logic [31:0] addr, input logic [3:0] mask,
                             input logic [31:0] data);
    int lane;
    for (int b = 0; b < 4; b++)
    begin
      lane = addr[2] ? b + 4 : b;
      if (mask[b])
        model_mem[addr[10:3]][lane*8 +: 8] = data[b*8 +: 8];
    end
  endtask

  // Stall must stay low for idle threads and rise one cycle after the request edge
  task automatic observe_threads();
    logic done_now;
    for (int t = 0; t < NUM_THREADS; t++)
    begin
      if (!busy[t])
      begin
        assert (!stall[t])
          else report_mismatch($sformatf("stall[%0d]", t), 32'(stall[t]), 32'd0);
      end
      else
      begin
        age[t]++;
        done_now = load_vld && (load.slice == 2'(t));
        if (age[t] <= 2)
        begin
          assert (stall[t] == (age[t] == 2))
            else report_mismatch($sformatf("stall[%0d]", t), 32'(stall[t]),
                                 32'(age[t] == 2));
        end
        else if (is_load[t])
        begin
          assert (stall[t] == !done_now)
            else report_mismatch($sformatf("stall[%0d]", t), 32'(stall[t]),
                                 32'(!done_now));
          if (done_now)
            busy[t] = 1'b0;
        end
        else if (!stall[t])
          busy[t] = 1'b0;
      end
    end
  endtask

  task automatic issue_request(input int t);
    logic [31:0] r;
    core_req_t   cr;
    load_ret_t   ret;
    rng_state = xorshift(rng_state);
    r         = rng_state;
    rng_state = xorshift(rng_state);
    cr        = '0;
    cr.data   = rng_state;
    if (ops_done[t] < INIT_OPS)
    begin
      cr.addr = region_addr(t, ops_done[t] / 2, ops_done[t][0]);
      cr.wr   = 1'b1;
      cr.mask = 4'b1111;
    end
    else
    begin
      cr.addr = region_addr(t, int'(r[6:4]), r[7]);
      cr.wr   = r[0];
      cr.mask = pick_mask(r[3:1]);
      cr.dst  = r[10:8];
    end
    if (cr.wr)
      apply_store(cr.addr, cr.mask, cr.data);
    else
    begin
      ret.slice = 2'(t);
      ret.dst   = cr.dst;
      ret.data  = expected_load(model_mem[cr.addr[10:3]], cr.addr, cr.mask);
      exp_q[t].push_back(ret);
      loads_issued++;
    end
    req        = cr;
    req_vld    = 1'b1;
    busy[t]    = 1'b1;
    is_load[t] = !cr.wr;
    age[t]     = 0;
    ops_done[t]++;
  endtask

  initial
  begin
    RST          = 1'b0;
    slice        = '0;
    req_vld      = 1'b0;
    req          = '0;
    rng_state    = 32'h86d97d4b;
    busy         = '0;
    is_load      = '0;
    loads_issued = 0;
    loads_seen   = 0;
    cycles       = 0;
    for (int t = 0; t < NUM_THREADS; t++)
    begin
      age[t]      = 0;
      ops_done[t] = 0;
    end
    #1 RST = 1'b1;
    repeat (5) @(negedge CLK);
    RST = 1'b0;
    while (work_left())
    begin
      @(negedge CLK);
      observe_threads();
      slice   = slice + 2'd1;
      req_vld = 1'b0;
      req     = '0;
      if (!busy[slice] && ops_done[slice] < OPS_PER_THREAD)
        issue_request(int'(slice));
    end
    repeat (2) @(negedge CLK);
    if (busy == '0 && stall == '0 && loads_seen == loads_issued)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
    begin
      report_failure("transactions still outstanding when the traffic ended");
    end
  end

  // Every returned load is matched against the oldest expectation of its thread
  always @(negedge CLK)
  begin
    if (!RST && load_vld)
    begin
      assert (exp_q[load.slice].size() != 0)
        else report_failure("load returned for a thread with no outstanding load");
      exp_ret = exp_q[load.slice].pop_front();
      assert (load.dst == exp_ret.dst)
        else report_mismatch("load.dst", 32'(load.dst), 32'(exp_ret.dst));
      assert (load.data == exp_ret.data)
        else report_mismatch("load.data", load.data, exp_ret.data);
      loads_seen++;
    end
  end

  always @(posedge CLK)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
      report_failure($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

endmodule

`default_nettype wire

/* compile.f */
hdl/bus_pkg.sv
hdl/thread_bus_unit.sv
hdl/mem_arbiter.sv
hdl/bus_memory.sv
hdl/bus_subsystem.sv
sim/bus_unit_checker.sv
sim/tb_bus_subsystem.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_bus_subsystem

out=$(./obj_dir/Vtb_bus_subsystem 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
  exit 0
else
  exit 1
fi
